// ==== list.f ====
+incdir+.
elink_link_pkg.sv
erx_pkg.sv
erx_deframer.sv
erx_router.sv
erx_fifo.sv
erx_top.sv
tb_erx.sv

// ==== tb_erx_tasks.svh ====
// directed tests for the mesh link receiver
// link serialization, output collection and the six test cases
`ifndef TB_ERX_TASKS_SVH
`define TB_ERX_TASKS_SVH

   // frame low for one cycle
   task automatic link_idle();
      @(negedge rx_lclk);
      link_in = '0;
   endtask

   // first transaction, header byte then fields msb first
   task automatic send_pkt(input emesh_packet_t p, input logic hold);
      logic [BYTES_PER_PKT*8-1:0] v;
      v = {8'(rand_bits(8)), p.ctrlmode, p.dstaddr, p.datamode, p.write, p.access,
           p.data, p.srcaddr};
      for (int i = 0; i < BYTES_PER_PKT / 2; i++)
      begin
         @(negedge rx_lclk);
         link_in.frame = 1'b1;
         // earlier byte in the upper half
         link_in.data  = v[BYTES_PER_PKT*8-1-16*i -: 16];
      end
      if (!hold)
         link_idle();
   endtask

   // burst follow-on, data then srcaddr
   task automatic send_follow(input logic [31:0] data, input logic [31:0] src,
                              input logic hold);
      logic [BURST_BYTES*8-1:0] v;
      v = {data, src};
      for (int i = 0; i < BURST_BYTES / 2; i++)
      begin
         @(negedge rx_lclk);
         link_in.frame = 1'b1;
         link_in.data  = v[BURST_BYTES*8-1-16*i -: 16];
      end
      if (!hold)
         link_idle();
   endtask

   // wait for one item on a port, check it, then take it
   task automatic expect_item(input string test, input logic is_wr, output int waited);
      logic prev;
      waited = 0;
      while (!(is_wr ? wr_valid : rd_valid))
      begin
         if (waited >= TIMEOUT)
            fail_stop($sformatf("%s: no item reached the %s port in time", test,
                                is_wr ? "write" : "read"));
         // the other port stays quiet
         check_val(test, "other port valid", 32'd0, is_wr ? rd_valid : wr_valid);
         @(negedge rx_lclk);
         waited++;
      end
      if (exp_q.size() == 0)
         fail_stop($sformatf("%s: an item arrived that was never sent", test));
      check_item(test, exp_q.pop_front(), is_wr ? wr_item : rd_item);
      prev = is_wr ? wr_ready : rd_ready;
      if (is_wr)
         wr_ready = 1'b1;
      else
         rd_ready = 1'b1;
      // transfer at the next rising edge
      @(negedge rx_lclk);
      if (is_wr)
         wr_ready = prev;
      else
         rd_ready = prev;
   endtask

   task automatic reset_and_write();
      emesh_packet_t p;
      int            waited;
      check_val("reset", "wr_valid", 32'd0, wr_valid);
      check_val("reset", "rd_valid", 32'd0, rd_valid);
      check_val("reset", "wr_wait", 32'd0, wr_wait);
      check_val("reset", "rd_wait", 32'd0, rd_wait);
      check_val("reset", "overflow", 32'd0, overflow);
      wr_ready = 1'b1;
      rd_ready = 1'b1;
      p = rand_pkt(1'b1);
      exp_q.push_back({p, 1'b0});
      send_pkt(p, 1'b0);
      expect_item("reset", 1'b1, waited);
      // 3 cycles after the last word, one already spent on the idle word
      check_val("reset", "latency", 32'd2, waited);
      wr_ready = 1'b0;
      rd_ready = 1'b0;
   endtask

   task automatic read_steering();
      emesh_packet_t p;
      int            waited;
      p = rand_pkt(1'b0);
      exp_q.push_back({p, 1'b0});
      send_pkt(p, 1'b0);
      expect_item("read", 1'b0, waited);
      check_val("read", "wr_valid", 32'd0, wr_valid);
   endtask

   // header transaction plus three follow-ons in one frame
   task automatic burst_sequence();
      emesh_packet_t p;
      emesh_packet_t f;
      int            waited;
      p = rand_pkt(1'b1);
      exp_q.push_back({p, 1'b0});
      send_pkt(p, 1'b1);
      for (int i = 1; i < 4; i++)
      begin
         f         = p;
         // address steps by 8 per follow-on
         f.dstaddr = p.dstaddr + 32'(8 * i);
         f.data    = rand_bits(32);
         f.srcaddr = rand_bits(32);
         exp_q.push_back({f, 1'b1});
         send_follow(f.data, f.srcaddr, i != 3);
      end
      repeat (4) expect_item("burst", 1'b1, waited);
   endtask

   task automatic backpressure_drain();
      emesh_packet_t p;
      int            waited;
      wr_ready = 1'b0;
      for (int n = 1; n <= FIFO_DEPTH - WAIT_SLACK; n++)
      begin
         p = rand_pkt(1'b1);
         exp_q.push_back({p, 1'b0});
         send_pkt(p, 1'b0);
         // queued two edges after the idle word
         repeat (2) @(negedge rx_lclk);
         check_val("backpressure", "wr_wait", n >= FIFO_DEPTH - WAIT_SLACK, wr_wait);
      end
      wr_ready = 1'b1;
      repeat (FIFO_DEPTH - WAIT_SLACK) expect_item("backpressure", 1'b1, waited);
      check_val("backpressure", "wr_wait after drain", 32'd0, wr_wait);
      check_val("backpressure", "wr_valid after drain", 32'd0, wr_valid);
      wr_ready = 1'b0;
   endtask

   // two writes more than the queue holds, wait ignored
   task automatic overflow_drop();
      emesh_packet_t p;
      int            waited;
      wr_ready = 1'b0;
      for (int n = 0; n < FIFO_DEPTH + 2; n++)
      begin
         p = rand_pkt(1'b1);
         if (n < FIFO_DEPTH)
            exp_q.push_back({p, 1'b0});
         send_pkt(p, 1'b0);
      end
      repeat (2) @(negedge rx_lclk);
      check_val("overflow", "overflow", 32'd1, overflow);
      wr_ready = 1'b1;
      repeat (FIFO_DEPTH) expect_item("overflow", 1'b1, waited);
      check_val("overflow", "overflow after drain", 32'd1, overflow);
      check_val("overflow", "wr_valid after drain", 32'd0, wr_valid);
      wr_ready = 1'b0;
   endtask

   task automatic aborted_frame();
      emesh_packet_t p;
      int            waited;
      // four words of a transaction, then frame drops
      repeat (4)
      begin
         @(negedge rx_lclk);
         link_in.frame = 1'b1;
         link_in.data  = 16'(rand_bits(16));
      end
      link_idle();
      repeat (8)
      begin
         @(negedge rx_lclk);
         check_val("abort", "wr_valid", 32'd0, wr_valid);
         check_val("abort", "rd_valid", 32'd0, rd_valid);
      end
      p = rand_pkt(1'b1);
      exp_q.push_back({p, 1'b0});
      send_pkt(p, 1'b0);
      expect_item("abort", 1'b1, waited);
   endtask

`endif

// ==== tb_erx.sv ====
// testbench for the mesh link receiver
// clock, reset, random source, checkers and the test sequence
`default_nettype none
`timescale 1ns/1ps

module tb_erx;
   import elink_link_pkg::*;
   import erx_pkg::*;

   // falling edges allowed per wait
   localparam int TIMEOUT = 50;

   logic        rx_lclk;
   logic        rst;
   link_word_t  link_in;
   logic        wr_wait;
   logic        rd_wait;
   logic        overflow;
   logic        wr_valid;
   logic        wr_ready;
   rx_item_t    wr_item;
   logic        rd_valid;
   logic        rd_ready;
   rx_item_t    rd_item;
   logic [31:0] lfsr;
   int          err_cnt;
   // items still expected at the outputs in arrival order
   rx_item_t    exp_q[$];

   erx_top DUT (
      .rx_lclk  (rx_lclk),
      .rst      (rst),
      .link_in  (link_in),
      .wr_wait  (wr_wait),
      .rd_wait  (rd_wait),
      .overflow (overflow),
      .wr_valid (wr_valid),
      .wr_ready (wr_ready),
      .wr_item  (wr_item),
      .rd_valid (rd_valid),
      .rd_ready (rd_ready),
      .rd_item  (rd_item)
   );

   // 100 ns link clock
   initial
   begin
      rx_lclk = 1'b0;
      forever #50 rx_lclk = ~rx_lclk;
   end

   // ####################################################################
   // random source
   // ####################################################################

   // one galois shift with taps 32 22 2 1
   function automatic logic [31:0] lfsr_step(input logic [31:0] s);
      logic [31:0] n;
      n = s >> 1;
      if (s[0])
         n = n ^ 32'h8020_0003;
      return n;
   endfunction

   // n fresh bits with one shift per bit
   function automatic logic [31:0] rand_bits(input int n);
      logic [31:0] v;
      v = '0;
      for (int i = 0; i < n; i++)
      begin
         v    = {v[30:0], lfsr[0]};
         lfsr = lfsr_step(lfsr);
      end
      return v;
   endfunction

   // random packet with the write bit chosen by the caller
   function automatic emesh_packet_t rand_pkt(input logic wr);
      emesh_packet_t p;
      p.access   = 1'(rand_bits(1));
      p.write    = wr;
      p.datamode = datamode_e'(2'(rand_bits(2)));
      p.ctrlmode = 4'(rand_bits(4));
      p.dstaddr  = rand_bits(32);
      p.data     = rand_bits(32);
      p.srcaddr  = rand_bits(32);
      return p;
   endfunction

   // ####################################################################
   // checkers
   // ####################################################################

   task automatic fail_stop(input string why);
      err_cnt++;
      $display("%s", why);
      $display("Simulation finished: FAIL");
      $fatal(1, "stopped at first error");
   endtask

   // single value such as a flag or count
   task automatic check_val(input string test, input string what,
                            input logic [31:0] exp, input logic [31:0] act);
      assert (act === exp)
      else
         fail_stop($sformatf("ERROR %s: %s expected %0h actual %0h", test, what, exp, act));
   endtask

   // whole item including the burst flag
   task automatic check_item(input string test, input rx_item_t exp, input rx_item_t act);
      assert (act === exp)
      else
         fail_stop($sformatf("ERROR %s: item expected %h actual %h", test, exp, act));
   endtask

   `include "tb_erx_tasks.svh"

   // ####################################################################
   // test sequence
   // ####################################################################

   initial
   begin
      err_cnt  = 0;
      lfsr     = 32'hb97aa08c;
      rst      = 1'b1;
      link_in  = '0;
      wr_ready = 1'b0;
      rd_ready = 1'b0;
      repeat (10) @(negedge rx_lclk);
      rst = 1'b0;
      @(negedge rx_lclk);
      reset_and_write();
      read_steering();
      burst_sequence();
      backpressure_drain();
      overflow_drop();
      aborted_frame();
      // no stray item at either port
      check_val("end", "wr_valid", 32'd0, wr_valid);
      check_val("end", "rd_valid", 32'd0, rd_valid);
      if (err_cnt == 0)
         $display("Simulation finished: PASS");
      else
         $display("Simulation finished: FAIL");
      $finish;
   end

endmodule

`default_nettype wire

// ==== erx_top.sv ====
// receive side of the mesh link
// deframer, router, and separate write and read queues
`default_nettype none
`timescale 1ns/1ps

module erx_top (
   input  logic                       rx_lclk,
   input  logic                       rst,
   input  elink_link_pkg::link_word_t link_in,
   output logic                       wr_wait,
   output logic                       rd_wait,
   output logic                       overflow,
   output logic                       wr_valid,
   input  logic                       wr_ready,
   output erx_pkg::rx_item_t          wr_item,
   output logic                       rd_valid,
   input  logic                       rd_ready,
   output erx_pkg::rx_item_t          rd_item
);
   import erx_pkg::*;

   logic     pkt_valid;
   rx_item_t pkt;
   logic     wr_push_valid;
   logic     rd_push_valid;
   rx_item_t push_item;
   logic     wr_push_ready;
   logic     rd_push_ready;

   // ####################################################################
   // pipeline
   // ####################################################################

   // two stages, link word to packet
   erx_deframer deframer (
      .rx_lclk   (rx_lclk),
      .rst       (rst),
      .link_in   (link_in),
      .pkt_valid (pkt_valid),
      .pkt       (pkt)
   );

   // same-cycle steering
   erx_router router (
      .rx_lclk       (rx_lclk),
      .rst           (rst),
      .pkt_valid     (pkt_valid),
      .pkt           (pkt),
      .wr_push_valid (wr_push_valid),
      .rd_push_valid (rd_push_valid),
      .push_item     (push_item),
      .wr_push_ready (wr_push_ready),
      .rd_push_ready (rd_push_ready),
      .overflow      (overflow)
   );

   // write queue, almost_full is the write wait
   erx_fifo wr_q (
      .rx_lclk     (rx_lclk),
      .rst         (rst),
      .push_valid  (wr_push_valid),
      .push_ready  (wr_push_ready),
      .push_item   (push_item),
      .pop_valid   (wr_valid),
      .pop_ready   (wr_ready),
      .pop_item    (wr_item),
      .almost_full (wr_wait)
   );

   // read queue
   erx_fifo rd_q (
      .rx_lclk     (rx_lclk),
      .rst         (rst),
      .push_valid  (rd_push_valid),
      .push_ready  (rd_push_ready),
      .push_item   (push_item),
      .pop_valid   (rd_valid),
      .pop_ready   (rd_ready),
      .pop_item    (rd_item),
      .almost_full (rd_wait)
   );

endmodule

`default_nettype wire

// ==== erx_fifo.sv ====
// packet queue with valid/ready on both sides
// raises almost_full early enough to cover packets in flight
`default_nettype none
`timescale 1ns/1ps

module erx_fifo (
   input  logic              rx_lclk,
   input  logic              rst,
   input  logic              push_valid,
   output logic              push_ready,
   input  erx_pkg::rx_item_t push_item,
   output logic              pop_valid,
   input  logic              pop_ready,
   output erx_pkg::rx_item_t pop_item,
   output logic              almost_full
);
   import erx_pkg::*;

   rx_item_t           mem [FIFO_DEPTH];
   logic [FIFO_AW-1:0] wr_ptr;
   logic [FIFO_AW-1:0] rd_ptr;
   logic [FIFO_CW-1:0] count;
   logic               do_push;
   logic               do_pop;

   // wrap at depth, works for any depth
   function automatic logic [FIFO_AW-1:0] ptr_inc(input logic [FIFO_AW-1:0] p);
      logic [FIFO_AW-1:0] n;
      if (p == FIFO_AW'(FIFO_DEPTH - 1))
         n = '0;
      else
         n = p + 1'b1;
      return n;
   endfunction

   // ####################################################################
   // handshakes and status
   // ####################################################################

   assign push_ready  = (count != FIFO_CW'(FIFO_DEPTH));
   assign pop_valid   = (count != '0);
   assign almost_full = (count >= FIFO_CW'(FIFO_AFULL));

   assign do_push = push_valid & push_ready;
   assign do_pop  = pop_valid & pop_ready;

   // head entry, stable until popped
   assign pop_item = mem[rd_ptr];

   // ####################################################################
   // storage and pointers
   // ####################################################################

   always_ff @(posedge rx_lclk)
   begin
      if (do_push)
         mem[wr_ptr] <= push_item;
   end

   always_ff @(posedge rx_lclk)
   begin
      if (rst)
      begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end
      else
      begin
         if (do_push)
            wr_ptr <= ptr_inc(wr_ptr);
         if (do_pop)
            rd_ptr <= ptr_inc(rd_ptr);
         // push and pop together leave the count alone
         case ({do_push, do_pop})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: count <= count;
         endcase
      end
   end

endmodule

`default_nettype wire

// ==== erx_router.sv ====
// packet router, steers by write bit into write or read queue
// drops at a full queue and keeps a sticky overflow flag
`default_nettype none
`timescale 1ns/1ps

module erx_router (
   input  logic              rx_lclk,
   input  logic              rst,
   input  logic              pkt_valid,
   input  erx_pkg::rx_item_t pkt,
   output logic              wr_push_valid,
   output logic              rd_push_valid,
   output erx_pkg::rx_item_t push_item,
   input  logic              wr_push_ready,
   input  logic              rd_push_ready,
   output logic              overflow
);

   logic to_wr;
   logic tgt_ready;
   logic drop;

   // ####################################################################
   // steering
   // ####################################################################

   // write bit picks the queue
   assign to_wr = pkt.pkt.write;

   // can the chosen queue take it now
   assign tgt_ready = to_wr ? wr_push_ready : rd_push_ready;

   // push only into a queue with room
   assign wr_push_valid = pkt_valid & to_wr & wr_push_ready;
   assign rd_push_valid = pkt_valid & ~to_wr & rd_push_ready;

   // both queues see the same item, valid selects
   assign push_item = pkt;

   // link cannot stall, so a full queue loses the packet
   assign drop = pkt_valid & ~tgt_ready;

   // ####################################################################
   // overflow flag
   // ####################################################################

   // sticky until reset
   always_ff @(posedge rx_lclk)
   begin
      if (rst)
         overflow <= 1'b0;
      else if (drop)
         overflow <= 1'b1;
   end

endmodule

`default_nettype wire

// ==== erx_deframer.sv ====
// link deframer that turns framed link words into mesh packets
// registers the link, tracks frame position and flags burst follow-ons
`default_nettype none
`timescale 1ns/1ps

module erx_deframer (
   input  logic                       rx_lclk,
   input  logic                       rst,
   input  elink_link_pkg::link_word_t link_in,
   output logic                       pkt_valid,
   output erx_pkg::rx_item_t          pkt
);
   import elink_link_pkg::*;
   import erx_pkg::*;

   // position within the frame
   typedef enum logic [1:0] {
      ST_IDLE,
      ST_HEADER,
      ST_BURST
   } state_e;

   link_word_t          in_q;
   state_e              state;
   logic [WORD_CW-1:0]  word_cnt;
   logic [SAMPLE_W-1:0] sample;
   logic [SAMPLE_W-1:0] sample_next;
   logic                hdr_done;
   logic                burst_done;
   emesh_packet_t       hdr_pkt;
   emesh_packet_t       burst_pkt;

   // ####################################################################
   // stage 1 input register
   // ####################################################################

   always_ff @(posedge rx_lclk)
   begin
      if (rst)
         in_q.frame <= 1'b0;
      else
         in_q.frame <= link_in.frame;
   end

   // link data word
   always_ff @(posedge rx_lclk)
   begin
      in_q.data <= link_in.data;
   end

   // ####################################################################
   // stage 2 frame tracking and assembly
   // ####################################################################

   // sample as it will look with the current word shifted in
   assign sample_next = {sample[SAMPLE_W-WORD_W-1:0], in_q.data};

   always_ff @(posedge rx_lclk)
   begin
      if (in_q.frame)
         sample <= sample_next;
   end

   // last word of first transaction
   assign hdr_done = in_q.frame && (state == ST_HEADER) &&
                     (word_cnt == WORD_CW'(WORDS_PER_PKT - 1));
   // last word of a follow-on
   assign burst_done = in_q.frame && (state == ST_BURST) &&
                       (word_cnt == WORD_CW'(WORDS_PER_BURST - 1));

   always_ff @(posedge rx_lclk)
   begin
      if (rst)
      begin
         state    <= ST_IDLE;
         word_cnt <= '0;
      end
      else if (!in_q.frame)
      begin
         // frame drop loses any partial transaction
         state    <= ST_IDLE;
         word_cnt <= '0;
      end
      else
      begin
         case (state)
            ST_IDLE:
            begin
               // this word is word 0 of the first transaction
               state    <= ST_HEADER;
               word_cnt <= WORD_CW'(1);
            end
            ST_HEADER:
            begin
               if (hdr_done)
               begin
                  // frame still high so follow-ons come next
                  state    <= ST_BURST;
                  word_cnt <= '0;
               end
               else
                  word_cnt <= word_cnt + 1'b1;
            end
            ST_BURST:
            begin
               if (burst_done)
                  word_cnt <= '0;
               else
                  word_cnt <= word_cnt + 1'b1;
            end
            default:
            begin
               state    <= ST_IDLE;
               word_cnt <= '0;
            end
         endcase
      end
   end

   // unpack first transaction with header byte in 111:104
   always_comb
   begin
      hdr_pkt.ctrlmode = sample_next[103:100];
      hdr_pkt.dstaddr  = sample_next[99:68];
      hdr_pkt.datamode = datamode_e'(sample_next[67:66]);
      hdr_pkt.write    = sample_next[65];
      hdr_pkt.access   = sample_next[64];
      hdr_pkt.data     = sample_next[63:32];
      hdr_pkt.srcaddr  = sample_next[31:0];
   end

   // follow-on reuses last header at the next address
   always_comb
   begin
      burst_pkt         = pkt.pkt;
      burst_pkt.dstaddr = pkt.pkt.dstaddr + 32'(BURST_ADDR_STEP);
      burst_pkt.data    = sample_next[63:32];
      burst_pkt.srcaddr = sample_next[31:0];
   end

   always_ff @(posedge rx_lclk)
   begin
      if (rst)
         pkt_valid <= 1'b0;
      else
         pkt_valid <= hdr_done | burst_done;
   end

   // output packet also holds header for the next follow-on
   always_ff @(posedge rx_lclk)
   begin
      if (hdr_done)
      begin
         pkt.pkt   <= hdr_pkt;
         pkt.burst <= 1'b0;
      end
      else if (burst_done)
      begin
         pkt.pkt   <= burst_pkt;
         pkt.burst <= 1'b1;
      end
   end

endmodule

`default_nettype wire

// ==== erx_pkg.sv ====
// mesh packet definitions for the receive path
// packet layout, queue item and queue sizing
`default_nettype none

package erx_pkg;

   // access size of a transaction
   typedef enum logic [1:0] {
      DM_BYTE   = 2'b00,
      DM_HALF   = 2'b01,
      DM_WORD   = 2'b10,
      DM_DOUBLE = 2'b11
   } datamode_e;

   // 104-bit mesh packet, msb first
   typedef struct packed {
      logic        access;
      logic        write;
      datamode_e   datamode;
      logic [3:0]  ctrlmode;
      logic [31:0] dstaddr;
      logic [31:0] data;
      logic [31:0] srcaddr;
   } emesh_packet_t;

   // packet as it moves through router and queues
   typedef struct packed {
      emesh_packet_t pkt;
      // set on burst follow-ons only
      logic          burst;
   } rx_item_t;

   // ####################################################################
   // queue sizing
   // ####################################################################

   localparam int FIFO_DEPTH = 8;
   // free entries kept for packets still on the link
   localparam int WAIT_SLACK = 3;
   // fill level that raises wait
   localparam int FIFO_AFULL = FIFO_DEPTH - WAIT_SLACK;

   localparam int FIFO_AW = $clog2(FIFO_DEPTH);
   // count must reach FIFO_DEPTH itself
   localparam int FIFO_CW = FIFO_AW + 1;

   // dstaddr increment per burst follow-on
   localparam int BURST_ADDR_STEP = 8;

endpackage

`default_nettype wire

// ==== elink_link_pkg.sv ====
// link-level definitions for the mesh link receiver
// word format and framing sizes
`default_nettype none

package elink_link_pkg;

   // bits delivered per rx_lclk, two bytes
   localparam int WORD_W = 16;

   // one sampled rx_lclk cycle of the link
   typedef struct packed {
      logic              frame;
      // upper byte came first on the wire
      logic [WORD_W-1:0] data;
   } link_word_t;

   // first transaction of a frame, header byte included
   localparam int BYTES_PER_PKT = 14;
   // each burst follow-on, data plus srcaddr
   localparam int BURST_BYTES = 8;

   localparam int WORDS_PER_PKT = BYTES_PER_PKT / (WORD_W / 8);
   localparam int WORDS_PER_BURST = BURST_BYTES / (WORD_W / 8);
   // deframer counter and sample register sizes
   localparam int WORD_CW = $clog2(WORDS_PER_PKT);
   localparam int SAMPLE_W = BYTES_PER_PKT * 8;

endpackage

`default_nettype wire
